/* rtl/lrsc_adapter.sv */
// Adds LR/SC exclusive access to a plain memory slave. Single beat only, one read and one write in flight
`timescale 1ns/1ns

module lrsc_adapter
    import lrsc_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_ni,

    // Master side
    input  ar_req_t slv_ar_i,
    input  logic    slv_ar_valid_i,
    output logic    slv_ar_ready_o,
    output r_beat_t slv_r_o,
    output logic    slv_r_valid_o,
    input  logic    slv_r_ready_i,
    input  aw_req_t slv_aw_i,
    input  logic    slv_aw_valid_i,
    output logic    slv_aw_ready_o,
    input  w_beat_t slv_w_i,
    input  logic    slv_w_valid_i,
    output logic    slv_w_ready_o,
    output b_beat_t slv_b_o,
    output logic    slv_b_valid_o,
    input  logic    slv_b_ready_i,

    // Slave side
    output ar_req_t mst_ar_o,
    output logic    mst_ar_valid_o,
    input  logic    mst_ar_ready_i,
    input  r_beat_t mst_r_i,
    input  logic    mst_r_valid_i,
    output logic    mst_r_ready_o,
    output aw_req_t mst_aw_o,
    output logic    mst_aw_valid_o,
    input  logic    mst_aw_ready_i,
    output w_beat_t mst_w_o,
    output logic    mst_w_valid_o,
    input  logic    mst_w_ready_i,
    input  b_beat_t mst_b_i,
    input  logic    mst_b_valid_i,
    output logic    mst_b_ready_o
);

    logic       res_set;
    word_addr_t res_set_addr;
    id_t        res_set_id;
    word_addr_t chk_addr;
    id_t        chk_id;
    logic       chk_match;
    logic       clr;
    word_addr_t clr_addr;
    wr_track_t  wr_track;

    lrsc_res_table u_res_table (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .set_i       (res_set),
        .set_addr_i  (res_set_addr),
        .set_id_i    (res_set_id),
        .chk_addr_i  (chk_addr),
        .chk_id_i    (chk_id),
        .chk_match_o (chk_match),
        .clr_i       (clr),
        .clr_addr_i  (clr_addr)
    );

    lrsc_read_ctrl u_read_ctrl (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .slv_ar_i       (slv_ar_i),
        .slv_ar_valid_i (slv_ar_valid_i),
        .slv_ar_ready_o (slv_ar_ready_o),
        .mst_ar_o       (mst_ar_o),
        .mst_ar_valid_o (mst_ar_valid_o),
        .mst_ar_ready_i (mst_ar_ready_i),
        .mst_r_i        (mst_r_i),
        .mst_r_valid_i  (mst_r_valid_i),
        .mst_r_ready_o  (mst_r_ready_o),
        .slv_r_o        (slv_r_o),
        .slv_r_valid_o  (slv_r_valid_o),
        .slv_r_ready_i  (slv_r_ready_i),
        .wr_track_i     (wr_track),
        .res_set_o      (res_set),
        .res_set_addr_o (res_set_addr),
        .res_set_id_o   (res_set_id)
    );

    lrsc_write_ctrl u_write_ctrl (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .slv_aw_i       (slv_aw_i),
        .slv_aw_valid_i (slv_aw_valid_i),
        .slv_aw_ready_o (slv_aw_ready_o),
        .slv_w_i        (slv_w_i),
        .slv_w_valid_i  (slv_w_valid_i),
        .slv_w_ready_o  (slv_w_ready_o),
        .slv_b_o        (slv_b_o),
        .slv_b_valid_o  (slv_b_valid_o),
        .slv_b_ready_i  (slv_b_ready_i),
        .mst_aw_o       (mst_aw_o),
        .mst_aw_valid_o (mst_aw_valid_o),
        .mst_aw_ready_i (mst_aw_ready_i),
        .mst_w_o        (mst_w_o),
        .mst_w_valid_o  (mst_w_valid_o),
        .mst_w_ready_i  (mst_w_ready_i),
        .mst_b_i        (mst_b_i),
        .mst_b_valid_i  (mst_b_valid_i),
        .mst_b_ready_o  (mst_b_ready_o),
        .slv_ar_i       (slv_ar_i),
        .slv_ar_valid_i (slv_ar_valid_i),
        .chk_addr_o     (chk_addr),
        .chk_id_o       (chk_id),
        .chk_match_i    (chk_match),
        .clr_o          (clr),
        .clr_addr_o     (clr_addr),
        .wr_track_o     (wr_track)
    );

endmodule

/* rtl/lrsc_pkg.sv */
// Shared types for the LR/SC adapter. The exclusive window bounds are fixed here and must stay word aligned
package lrsc_pkg;

    localparam int ADDR_W   = 16;
    localparam int DATA_W   = 32;
    localparam int ID_W     = 2;
    localparam int N_IDS    = 4;
    localparam int WORD_LSB = 2;

    typedef logic [ADDR_W-1:0]          addr_t;
    typedef logic [ADDR_W-WORD_LSB-1:0] word_addr_t;
    typedef logic [DATA_W-1:0]          data_t;
    typedef logic [ID_W-1:0]            id_t;

    // Closed interval of byte addresses that support exclusive access
    localparam addr_t EXCL_BEGIN = 16'h1000;
    localparam addr_t EXCL_END   = 16'h1fff;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_e;

    typedef struct packed {
        addr_t addr;
        id_t   id;
        logic  lock;
    } ar_req_t;

    typedef struct packed {
        addr_t addr;
        id_t   id;
        logic  lock;
    } aw_req_t;

    typedef struct packed {
        data_t             data;
        logic [DATA_W/8-1:0] strb;
    } w_beat_t;

    typedef struct packed {
        data_t data;
        id_t   id;
        resp_e resp;
    } r_beat_t;

    typedef struct packed {
        id_t   id;
        resp_e resp;
    } b_beat_t;

    // Write that has been forwarded downstream and not yet answered
    typedef struct packed {
        logic       busy;
        word_addr_t addr;
    } wr_track_t;

    typedef enum logic [1:0] {
        AW_IDLE,
        AW_FWD,
        W_WAIT,
        B_WAIT
    } aw_state_e;

    function automatic logic in_excl_window(addr_t addr);
        return (addr >= EXCL_BEGIN) && (addr <= EXCL_END);
    endfunction

    function automatic word_addr_t word_of(addr_t addr);
        return addr[ADDR_W-1:WORD_LSB];
    endfunction

endpackage

/* rtl/lrsc_read_ctrl.sv */
// One read in flight at a time. Exclusive reads count only inside the window and are single beat
`timescale 1ns/1ns

module lrsc_read_ctrl
    import lrsc_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,

    input  ar_req_t    slv_ar_i,
    input  logic       slv_ar_valid_i,
    output logic       slv_ar_ready_o,

    output ar_req_t    mst_ar_o,
    output logic       mst_ar_valid_o,
    input  logic       mst_ar_ready_i,

    input  r_beat_t    mst_r_i,
    input  logic       mst_r_valid_i,
    output logic       mst_r_ready_o,

    output r_beat_t    slv_r_o,
    output logic       slv_r_valid_o,
    input  logic       slv_r_ready_i,

    input  wr_track_t  wr_track_i,

    output logic       res_set_o,
    output word_addr_t res_set_addr_o,
    output id_t        res_set_id_o
);

    logic rd_busy_q;
    logic rd_excl_q;
    logic ar_excl;
    logic ar_fire;
    logic r_fire;
    logic wr_same_word;

    assign ar_excl = slv_ar_i.lock && in_excl_window(slv_ar_i.addr);

    // Downstream slave never sees the lock bit
    assign mst_ar_o       = '{addr: slv_ar_i.addr, id: slv_ar_i.id, lock: 1'b0};
    assign mst_ar_valid_o = slv_ar_valid_i && !rd_busy_q;
    assign slv_ar_ready_o = mst_ar_ready_i && !rd_busy_q;
    assign ar_fire        = mst_ar_valid_o && mst_ar_ready_i;

    // No reservation while a write to the same word is still on its way
    assign wr_same_word   = wr_track_i.busy && (wr_track_i.addr == word_of(slv_ar_i.addr));
    assign res_set_o      = ar_fire && ar_excl && !wr_same_word;
    assign res_set_addr_o = word_of(slv_ar_i.addr);
    assign res_set_id_o   = slv_ar_i.id;

    assign slv_r_valid_o = mst_r_valid_i && rd_busy_q;
    assign mst_r_ready_o = slv_r_ready_i && rd_busy_q;
    assign r_fire        = slv_r_valid_o && slv_r_ready_i;

    always_comb begin
        slv_r_o = mst_r_i;
        // Error responses pass unchanged
        if (!mst_r_i.resp[1]) begin
            slv_r_o.resp = rd_excl_q ? EXOKAY : OKAY;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_busy_q <= 1'b0;
            rd_excl_q <= 1'b0;
        end else if (ar_fire) begin
            rd_busy_q <= 1'b1;
            rd_excl_q <= ar_excl;
        end else if (r_fire) begin
            rd_busy_q <= 1'b0;
        end
    end

endmodule

/* rtl/lrsc_res_table.sv */
// One reservation per ID. A set and a clear of the same word in one cycle leave the word unreserved
`timescale 1ns/1ns

module lrsc_res_table
    import lrsc_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,

    // Set from the read side
    input  logic       set_i,
    input  word_addr_t set_addr_i,
    input  id_t        set_id_i,

    // Check from the write side
    input  word_addr_t chk_addr_i,
    input  id_t        chk_id_i,
    output logic       chk_match_o,

    // Clear of every entry on one word
    input  logic       clr_i,
    input  word_addr_t clr_addr_i
);

    logic [N_IDS-1:0] valid_q;
    logic [N_IDS-1:0] valid_d;
    word_addr_t       addr_q [N_IDS];

    always_comb begin
        valid_d = valid_q;
        for (int i = 0; i < N_IDS; i++) begin
            if (clr_i && (addr_q[i] == clr_addr_i)) begin
                valid_d[i] = 1'b0;
            end
            // A new reservation is dead on arrival if its word is cleared now
            if (set_i && (set_id_i == id_t'(i))) begin
                valid_d[i] = !(clr_i && (clr_addr_i == set_addr_i));
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (set_i) begin
            addr_q[set_id_i] <= set_addr_i;
        end
    end

    assign chk_match_o = valid_q[chk_id_i] && (addr_q[chk_id_i] == chk_addr_i);

endmodule

/* rtl/lrsc_write_ctrl.sv */
// One write in flight at a time. An exclusive write without a reservation is dropped and answered OKAY
`timescale 1ns/1ns

module lrsc_write_ctrl
    import lrsc_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,

    input  aw_req_t    slv_aw_i,
    input  logic       slv_aw_valid_i,
    output logic       slv_aw_ready_o,

    input  w_beat_t    slv_w_i,
    input  logic       slv_w_valid_i,
    output logic       slv_w_ready_o,

    output b_beat_t    slv_b_o,
    output logic       slv_b_valid_o,
    input  logic       slv_b_ready_i,

    output aw_req_t    mst_aw_o,
    output logic       mst_aw_valid_o,
    input  logic       mst_aw_ready_i,

    output w_beat_t    mst_w_o,
    output logic       mst_w_valid_o,
    input  logic       mst_w_ready_i,

    input  b_beat_t    mst_b_i,
    input  logic       mst_b_valid_i,
    output logic       mst_b_ready_o,

    // Pending read request of the master
    input  ar_req_t    slv_ar_i,
    input  logic       slv_ar_valid_i,

    output word_addr_t chk_addr_o,
    output id_t        chk_id_o,
    input  logic       chk_match_i,

    output logic       clr_o,
    output word_addr_t clr_addr_o,

    output wr_track_t  wr_track_o
);

    aw_state_e  state_q;
    aw_state_e  state_d;
    logic       fwd_q;
    logic       excl_q;
    id_t        id_q;
    word_addr_t waddr_q;

    word_addr_t aw_word;
    logic       aw_in_win;
    logic       aw_excl;
    logic       aw_fwd;
    logic       ar_conflict;
    logic       capture;

    assign aw_word   = word_of(slv_aw_i.addr);
    assign aw_in_win = in_excl_window(slv_aw_i.addr);
    assign aw_excl   = slv_aw_i.lock && aw_in_win;
    // Plain writes always go through, exclusive ones only with a reservation
    assign aw_fwd    = !aw_excl || chk_match_i;

    // Exclusive read waiting on the same word goes first
    assign ar_conflict = aw_in_win && slv_ar_valid_i && slv_ar_i.lock
                         && (word_of(slv_ar_i.addr) == aw_word);

    assign chk_addr_o = aw_word;
    assign chk_id_o   = slv_aw_i.id;

    assign mst_aw_o = '{addr: slv_aw_i.addr, id: slv_aw_i.id, lock: 1'b0};
    assign mst_w_o  = slv_w_i;

    // Every in-window write that reaches the slave kills the reservations on its word
    assign clr_o      = mst_aw_valid_o && mst_aw_ready_i && aw_in_win;
    assign clr_addr_o = aw_word;

    assign wr_track_o = '{busy: fwd_q && (state_q != AW_IDLE), addr: waddr_q};

    always_comb begin
        state_d        = state_q;
        capture        = 1'b0;
        slv_aw_ready_o = 1'b0;
        mst_aw_valid_o = 1'b0;
        slv_w_ready_o  = 1'b0;
        mst_w_valid_o  = 1'b0;
        mst_b_ready_o  = 1'b0;
        slv_b_valid_o  = 1'b0;
        slv_b_o        = mst_b_i;

        unique case (state_q)
            AW_IDLE: begin
                if (slv_aw_valid_i && !ar_conflict) begin
                    capture = 1'b1;
                    if (aw_fwd) begin
                        mst_aw_valid_o = 1'b1;
                        slv_aw_ready_o = mst_aw_ready_i;
                        state_d        = mst_aw_ready_i ? W_WAIT : AW_FWD;
                    end else begin
                        // Drop the AW right away
                        slv_aw_ready_o = 1'b1;
                        state_d        = W_WAIT;
                    end
                end
            end

            AW_FWD: begin
                // Decision is taken, just wait for the slave
                mst_aw_valid_o = slv_aw_valid_i;
                slv_aw_ready_o = mst_aw_ready_i;
                if (slv_aw_valid_i && mst_aw_ready_i) begin
                    state_d = W_WAIT;
                end
            end

            W_WAIT: begin
                if (fwd_q) begin
                    mst_w_valid_o = slv_w_valid_i;
                    slv_w_ready_o = mst_w_ready_i;
                    if (slv_w_valid_i && mst_w_ready_i) begin
                        state_d = B_WAIT;
                    end
                end else begin
                    slv_w_ready_o = 1'b1;
                    if (slv_w_valid_i) begin
                        state_d = B_WAIT;
                    end
                end
            end

            B_WAIT: begin
                if (fwd_q) begin
                    slv_b_valid_o = mst_b_valid_i;
                    mst_b_ready_o = slv_b_ready_i;
                    if (!mst_b_i.resp[1]) begin
                        slv_b_o.resp = excl_q ? EXOKAY : OKAY;
                    end
                    if (mst_b_valid_i && slv_b_ready_i) begin
                        state_d = AW_IDLE;
                    end
                end else begin
                    // Injected response for the dropped write
                    slv_b_valid_o = 1'b1;
                    slv_b_o       = '{id: id_q, resp: OKAY};
                    if (slv_b_ready_i) begin
                        state_d = AW_IDLE;
                    end
                end
            end

            default: begin
                state_d = AW_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= AW_IDLE;
            fwd_q   <= 1'b0;
            excl_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (capture) begin
                fwd_q  <= aw_fwd;
                excl_q <= aw_excl && chk_match_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture) begin
            id_q    <= slv_aw_i.id;
            waddr_q <= aw_word;
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module tb_lrsc -f tb.f -o sim_lrsc
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_lrsc)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "PASS: all tests"; then
    exit 0
fi
exit 1

/* tb.f */
rtl/lrsc_pkg.sv
rtl/lrsc_res_table.sv
rtl/lrsc_read_ctrl.sv
rtl/lrsc_write_ctrl.sv
rtl/lrsc_adapter.sv
testbench/lrsc_props.sv
testbench/tb_lrsc.sv

/* testbench/lrsc_props.sv */
// Handshake, reset and lock checks for the adapter ports. Bound into every lrsc_adapter instance
`timescale 1ns/1ns

module lrsc_props
    import lrsc_pkg::*;
(
    input logic    clk_i,
    input logic    rst_ni,
    input logic    slv_ar_ready_o,
    input r_beat_t slv_r_o,
    input logic    slv_r_valid_o,
    input logic    slv_r_ready_i,
    input logic    slv_aw_ready_o,
    input logic    slv_w_ready_o,
    input b_beat_t slv_b_o,
    input logic    slv_b_valid_o,
    input logic    slv_b_ready_i,
    input ar_req_t mst_ar_o,
    input logic    mst_ar_valid_o,
    input logic    mst_ar_ready_i,
    input aw_req_t mst_aw_o,
    input logic    mst_aw_valid_o,
    input logic    mst_aw_ready_i,
    input w_beat_t mst_w_o,
    input logic    mst_w_valid_o,
    input logic    mst_w_ready_i,
    input logic    mst_r_ready_o,
    input logic    mst_b_ready_o
);

    // Held valids keep their payload until the handshake
    a_r_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        slv_r_valid_o && !slv_r_ready_i |=> slv_r_valid_o && $stable(slv_r_o))
        else $error("R valid or data changed before ready");
    a_b_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        slv_b_valid_o && !slv_b_ready_i |=> slv_b_valid_o && $stable(slv_b_o))
        else $error("B valid or data changed before ready");
    a_ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mst_ar_valid_o && !mst_ar_ready_i |=> mst_ar_valid_o && $stable(mst_ar_o))
        else $error("AR valid or data changed before ready");
    a_aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mst_aw_valid_o && !mst_aw_ready_i |=> mst_aw_valid_o && $stable(mst_aw_o))
        else $error("AW valid or data changed before ready");
    a_w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mst_w_valid_o && !mst_w_ready_i |=> mst_w_valid_o && $stable(mst_w_o))
        else $error("W valid or data changed before ready");

    a_reset_quiet: assert property (@(posedge clk_i) !rst_ni |->
        !(slv_ar_ready_o || slv_r_valid_o || slv_aw_ready_o || slv_w_ready_o
          || slv_b_valid_o || mst_ar_valid_o || mst_aw_valid_o || mst_w_valid_o
          || mst_r_ready_o || mst_b_ready_o))
        else $error("Valid or ready output high during reset");

    // Slave never sees an exclusive request
    a_ar_no_lock: assert property (@(posedge clk_i) mst_ar_valid_o |-> !mst_ar_o.lock)
        else $error("Lock bit set on downstream AR");
    a_aw_no_lock: assert property (@(posedge clk_i) mst_aw_valid_o |-> !mst_aw_o.lock)
        else $error("Lock bit set on downstream AW");

endmodule

bind lrsc_adapter lrsc_props u_props (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .slv_ar_ready_o(slv_ar_ready_o), .slv_r_o(slv_r_o), .slv_r_valid_o(slv_r_valid_o),
    .slv_r_ready_i(slv_r_ready_i), .slv_aw_ready_o(slv_aw_ready_o),
    .slv_w_ready_o(slv_w_ready_o), .slv_b_o(slv_b_o), .slv_b_valid_o(slv_b_valid_o),
    .slv_b_ready_i(slv_b_ready_i), .mst_ar_o(mst_ar_o), .mst_ar_valid_o(mst_ar_valid_o),
    .mst_ar_ready_i(mst_ar_ready_i), .mst_aw_o(mst_aw_o), .mst_aw_valid_o(mst_aw_valid_o),
    .mst_aw_ready_i(mst_aw_ready_i), .mst_w_o(mst_w_o), .mst_w_valid_o(mst_w_valid_o),
    .mst_w_ready_i(mst_w_ready_i), .mst_r_ready_o(mst_r_ready_o),
    .mst_b_ready_o(mst_b_ready_o)
);

/* testbench/tb_lrsc.sv */
// Single master and a behavioral memory slave with random ready delays; stops at the first error
`timescale 1ns/1ns

module tb_lrsc
    import lrsc_pkg::*;
();

    localparam addr_t ERR_BEGIN   = 16'h3000;
    localparam addr_t ERR_END     = 16'h30ff;
    localparam int    N_WORDS     = 2**(ADDR_W-WORD_LSB);
    localparam int    CYCLE_LIMIT = 20000;

    logic clk_i = 1'b0;
    logic rst_ni;

    ar_req_t slv_ar;
    logic    slv_ar_valid;
    logic    slv_ar_ready_o;
    r_beat_t slv_r_o;
    logic    slv_r_valid_o;
    logic    slv_r_ready;
    aw_req_t slv_aw;
    logic    slv_aw_valid;
    logic    slv_aw_ready_o;
    w_beat_t slv_w;
    logic    slv_w_valid;
    logic    slv_w_ready_o;
    b_beat_t slv_b_o;
    logic    slv_b_valid_o;
    logic    slv_b_ready;

    ar_req_t mst_ar_o;
    logic    mst_ar_valid_o;
    logic    mst_ar_ready = 1'b0;
    r_beat_t mst_r        = '0;
    logic    mst_r_valid  = 1'b0;
    logic    mst_r_ready_o;
    aw_req_t mst_aw_o;
    logic    mst_aw_valid_o;
    logic    mst_aw_ready = 1'b0;
    w_beat_t mst_w_o;
    logic    mst_w_valid_o;
    logic    mst_w_ready  = 1'b0;
    b_beat_t mst_b        = '0;
    logic    mst_b_valid  = 1'b0;
    logic    mst_b_ready_o;

    logic [31:0] lfsr_q   = 32'h0e5fb59e;
    logic [1:0]  ar_dly   = 2'd0;
    logic [1:0]  aw_dly   = 2'd0;
    logic [1:0]  w_dly    = 2'd0;
    logic        aw_got   = 1'b0;
    addr_t       aw_addr  = '0;
    id_t         aw_id    = '0;
    data_t       mem    [N_WORDS];
    data_t       shadow [N_WORDS];
    int unsigned cycles   = 0;

    lrsc_adapter u_lrsc_adapter (
        .clk_i, .rst_ni,
        .slv_ar_i(slv_ar), .slv_ar_valid_i(slv_ar_valid), .slv_ar_ready_o,
        .slv_r_o, .slv_r_valid_o, .slv_r_ready_i(slv_r_ready),
        .slv_aw_i(slv_aw), .slv_aw_valid_i(slv_aw_valid), .slv_aw_ready_o,
        .slv_w_i(slv_w), .slv_w_valid_i(slv_w_valid), .slv_w_ready_o,
        .slv_b_o, .slv_b_valid_o, .slv_b_ready_i(slv_b_ready),
        .mst_ar_o, .mst_ar_valid_o, .mst_ar_ready_i(mst_ar_ready),
        .mst_r_i(mst_r), .mst_r_valid_i(mst_r_valid), .mst_r_ready_o,
        .mst_aw_o, .mst_aw_valid_o, .mst_aw_ready_i(mst_aw_ready),
        .mst_w_o, .mst_w_valid_o, .mst_w_ready_i(mst_w_ready),
        .mst_b_i(mst_b), .mst_b_valid_i(mst_b_valid), .mst_b_ready_o
    );

    initial begin
        forever #5 clk_i = ~clk_i;
    end

    // Galois LFSR, one step per bit
    function automatic logic [1:0] rand_bits2();
        logic [1:0] v;
        v = 2'd0;
        for (int i = 0; i < 2; i++) begin
            v      = {v[0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    function automatic data_t fill_word(input word_addr_t w);
        return {2'b10, w, 2'b01, w} ^ 32'h5a5a0000;
    endfunction

    function automatic logic in_err(input addr_t a);
        return (a >= ERR_BEGIN) && (a <= ERR_END);
    endfunction

    // Memory slave, SLVERR and no write in the error region
    always @(posedge clk_i) begin
        if (!rst_ni) begin
            mst_ar_ready <= 1'b0;
            mst_r_valid  <= 1'b0;
            mst_aw_ready <= 1'b0;
            mst_w_ready  <= 1'b0;
            mst_b_valid  <= 1'b0;
            aw_got       <= 1'b0;
            for (int i = 0; i < N_WORDS; i++) begin
                mem[i] <= fill_word(word_addr_t'(i));
            end
        end else begin
            if (mst_ar_valid_o && mst_ar_ready) begin
                mst_ar_ready <= 1'b0;
                mst_r_valid  <= 1'b1;
                mst_r        <= '{data: mem[mst_ar_o.addr[ADDR_W-1:WORD_LSB]], id: mst_ar_o.id,
                                  resp: in_err(mst_ar_o.addr) ? SLVERR : OKAY};
                ar_dly       <= rand_bits2();
            end else if (mst_ar_valid_o) begin
                if (ar_dly == 2'd0) mst_ar_ready <= 1'b1;
                else ar_dly <= ar_dly - 2'd1;
            end
            if (mst_r_valid && mst_r_ready_o) mst_r_valid <= 1'b0;

            if (mst_aw_valid_o && mst_aw_ready) begin
                mst_aw_ready <= 1'b0;
                aw_got       <= 1'b1;
                aw_addr      <= mst_aw_o.addr;
                aw_id        <= mst_aw_o.id;
                aw_dly       <= rand_bits2();
            end else if (mst_aw_valid_o && !aw_got) begin
                if (aw_dly == 2'd0) mst_aw_ready <= 1'b1;
                else aw_dly <= aw_dly - 2'd1;
            end

            if (mst_w_valid_o && mst_w_ready) begin
                mst_w_ready <= 1'b0;
                aw_got      <= 1'b0;
                if (!in_err(aw_addr)) mem[aw_addr[ADDR_W-1:WORD_LSB]] <= mst_w_o.data;
                mst_b_valid <= 1'b1;
                mst_b       <= '{id: aw_id, resp: in_err(aw_addr) ? SLVERR : OKAY};
                w_dly       <= rand_bits2();
            end else if (mst_w_valid_o && aw_got) begin
                if (w_dly == 2'd0) mst_w_ready <= 1'b1;
                else w_dly <= w_dly - 2'd1;
            end
            if (mst_b_valid && mst_b_ready_o) mst_b_valid <= 1'b0;
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act) else begin
            $display("error %s: expected %h, actual %h", name, exp, act);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    task automatic read_word(input addr_t a, input id_t id, input logic lock,
                             output data_t d, output resp_e r, output id_t rid);
        @(posedge clk_i);
        slv_ar       <= '{addr: a, id: id, lock: lock};
        slv_ar_valid <= 1'b1;
        do @(posedge clk_i); while (!slv_ar_ready_o);
        slv_ar_valid <= 1'b0;
        // One cycle of back-pressure on R
        @(posedge clk_i);
        slv_r_ready  <= 1'b1;
        do @(posedge clk_i); while (!slv_r_valid_o);
        d   = slv_r_o.data;
        r   = slv_r_o.resp;
        rid = slv_r_o.id;
        slv_r_ready <= 1'b0;
    endtask

    task automatic write_word(input addr_t a, input id_t id, input logic lock, input data_t d,
                              output resp_e r, output id_t bid);
        logic aw_done;
        logic w_done;
        aw_done = 1'b0;
        w_done  = 1'b0;
        @(posedge clk_i);
        slv_aw       <= '{addr: a, id: id, lock: lock};
        slv_aw_valid <= 1'b1;
        slv_w        <= '{data: d, strb: 4'hf};
        slv_w_valid  <= 1'b1;
        while (!(aw_done && w_done)) begin
            @(posedge clk_i);
            if (!aw_done && slv_aw_ready_o) begin
                aw_done = 1'b1;
                slv_aw_valid <= 1'b0;
            end
            if (!w_done && slv_w_ready_o) begin
                w_done = 1'b1;
                slv_w_valid <= 1'b0;
            end
        end
        // One cycle of back-pressure on B
        @(posedge clk_i);
        slv_b_ready <= 1'b1;
        do @(posedge clk_i); while (!slv_b_valid_o);
        r   = slv_b_o.resp;
        bid = slv_b_o.id;
        slv_b_ready <= 1'b0;
    endtask

    // Write with expected B, shadow follows only when the write should land
    task automatic write_expect(input string name, input addr_t a, input id_t id,
                                input logic lock, input data_t d, input resp_e exp, input logic lands);
        resp_e r;
        id_t   bid;
        write_word(a, id, lock, d, r, bid);
        check_value({name, " b resp"}, 32'(exp), 32'(r));
        check_value({name, " b id"}, 32'(id), 32'(bid));
        if (lands) shadow[a[ADDR_W-1:WORD_LSB]] = d;
    endtask

    task automatic read_expect(input string name, input addr_t a, input id_t id,
                               input logic lock, input resp_e exp);
        data_t d;
        resp_e r;
        id_t   rid;
        read_word(a, id, lock, d, r, rid);
        check_value({name, " r resp"}, 32'(exp), 32'(r));
        check_value({name, " r id"}, 32'(id), 32'(rid));
        check_value({name, " r data"}, shadow[a[ADDR_W-1:WORD_LSB]], d);
    endtask

    initial begin
        rst_ni       = 1'b0;
        slv_ar       = '0;
        slv_ar_valid = 1'b0;
        slv_r_ready  = 1'b0;
        slv_aw       = '0;
        slv_aw_valid = 1'b0;
        slv_w        = '0;
        slv_w_valid  = 1'b0;
        slv_b_ready  = 1'b0;
        for (int i = 0; i < N_WORDS; i++) begin
            shadow[i] = fill_word(word_addr_t'(i));
        end
        repeat (5) @(posedge clk_i);
        rst_ni <= 1'b1;

        write_expect("plain_in", 16'h1010, 2'd0, 1'b0, 32'h11111111, OKAY, 1'b1);
        read_expect("plain_in", 16'h1010, 2'd0, 1'b0, OKAY);
        write_expect("plain_out", 16'h0040, 2'd2, 1'b0, 32'h22222222, OKAY, 1'b1);
        read_expect("plain_out", 16'h0040, 2'd2, 1'b0, OKAY);

        read_expect("excl_ok", 16'h1100, 2'd1, 1'b1, EXOKAY);
        write_expect("excl_ok", 16'h1100, 2'd1, 1'b1, 32'hcafe0001, EXOKAY, 1'b1);
        read_expect("excl_ok after", 16'h1100, 2'd1, 1'b0, OKAY);

        // No reservation so the write is dropped
        write_expect("excl_none", 16'h1200, 2'd2, 1'b1, 32'hdead0002, OKAY, 1'b0);
        read_expect("excl_none after", 16'h1200, 2'd2, 1'b0, OKAY);

        read_expect("excl_lost", 16'h1300, 2'd0, 1'b1, EXOKAY);
        // ID 1 holds the neighbouring word across the clear of 16'h1300
        read_expect("excl_keep", 16'h1304, 2'd1, 1'b1, EXOKAY);
        write_expect("excl_lost other", 16'h1300, 2'd3, 1'b0, 32'h33333333, OKAY, 1'b1);
        write_expect("excl_lost", 16'h1300, 2'd0, 1'b1, 32'hbad00000, OKAY, 1'b0);
        write_expect("excl_keep", 16'h1304, 2'd1, 1'b1, 32'h77777777, EXOKAY, 1'b1);
        read_expect("excl_lost after", 16'h1300, 2'd0, 1'b0, OKAY);
        read_expect("excl_next", 16'h1304, 2'd0, 1'b1, EXOKAY);
        write_expect("excl_next", 16'h1304, 2'd0, 1'b1, 32'h0badf00d, EXOKAY, 1'b1);
        read_expect("excl_next after", 16'h1304, 2'd0, 1'b0, OKAY);

        read_expect("excl_outside", 16'h2000, 2'd1, 1'b1, OKAY);
        write_expect("excl_outside", 16'h2000, 2'd1, 1'b1, 32'h44444444, OKAY, 1'b1);
        read_expect("excl_outside after", 16'h2000, 2'd1, 1'b0, OKAY);

        read_expect("err_plain", 16'h3010, 2'd3, 1'b0, SLVERR);
        write_expect("err_plain", 16'h3010, 2'd3, 1'b0, 32'h55555555, SLVERR, 1'b0);
        read_expect("err_excl", 16'h3010, 2'd2, 1'b1, SLVERR);
        write_expect("err_excl", 16'h3010, 2'd2, 1'b1, 32'h66666666, SLVERR, 1'b0);

        repeat (3) @(posedge clk_i);
        $display("PASS: all tests");
        $finish;
    end

endmodule
